//--- design/spi_pkg.sv
/*
 * serial framing types shared by the receiver, the register bank and the testbench
 * one write strobe carries a single register update out of the deserializer
 */
package spi_pkg;

    // bits per byte slot on serial_in / serial_out
    localparam int BYTE_BITS = 8;

    typedef logic [BYTE_BITS-1:0] byte_t;   // one serial byte, msb first on the wire
    typedef logic [7:0]           addr_t;   // register address, first byte of a frame

    // single-cycle register write, valid for exactly one sclk
    typedef struct packed {
        logic  valid;
        addr_t addr;
        byte_t data;
    } wr_strobe_t;

endpackage

//--- design/regmap_pkg.sv
/*
 * register map of the configuration peripheral
 * addresses, instruction codes and the packed register image with its reset value
 */
package regmap_pkg;

    // writable registers
    localparam spi_pkg::addr_t ADDR_TRIG_MASK   = 8'd1;
    localparam spi_pkg::addr_t ADDR_INSTRUCTION = 8'd2;
    localparam spi_pkg::addr_t ADDR_MODE        = 8'd3;

    // read-only, driven from the pll
    localparam spi_pkg::addr_t ADDR_PLL_LOCKED  = 8'd60;

    // upper block, after the analog shift-register range
    localparam spi_pkg::addr_t ADDR_DISC_POL    = 8'd61;
    localparam spi_pkg::addr_t ADDR_VCO_CTRL    = 8'd62;
    localparam spi_pkg::addr_t ADDR_PLL_DIV     = 8'd63;
    localparam spi_pkg::addr_t ADDR_SLOW_MODE   = 8'd64;
    localparam spi_pkg::addr_t ADDR_TRIG_DELAY  = 8'd65;

    // instruction register codes, anything else is ignored
    localparam spi_pkg::byte_t INST_RESET   = 8'd1;
    localparam spi_pkg::byte_t INST_READOUT = 8'd2;
    localparam spi_pkg::byte_t INST_START   = 8'd3;   // also holds clk_enable high

    // full register image as seen on the cfg output
    typedef struct packed {
        spi_pkg::byte_t trig_mask;
        spi_pkg::byte_t instruction;
        spi_pkg::byte_t mode;
        spi_pkg::byte_t disc_pol;
        spi_pkg::byte_t vco_ctrl;
        spi_pkg::byte_t pll_div;
        spi_pkg::byte_t slow_mode;
        spi_pkg::byte_t trig_delay;
    } cfg_regs_t;

    localparam cfg_regs_t CFG_RESET = '{
        trig_mask:   8'h00,
        instruction: 8'h00,
        mode:        8'h00,
        disc_pol:    8'h00,
        vco_ctrl:    8'h00,
        pll_div:     8'h00,
        slow_mode:   8'h00,
        trig_delay:  8'h00
    };

endpackage

//--- design/spi_frame_rx.sv
/*
 * serial deserializer, framed by csn low; first byte is the address, the rest are data
 * emits one write strobe per data byte and marks byte slots and the end of a frame
 */
`timescale 1ns/1ps

module spi_frame_rx (
    input  logic                sclk,
    input  logic                rstn,
    input  logic                csn,
    input  logic                serial_in,
    output spi_pkg::wr_strobe_t wr,
    output spi_pkg::addr_t      cur_addr,
    output logic                slot_start,
    output logic                frame_end
);

    localparam int CNT_W = $clog2(spi_pkg::BYTE_BITS);

    logic [spi_pkg::BYTE_BITS-2:0] shift_q;    // first seven bits of the byte in flight
    logic [CNT_W-1:0]              bit_cnt;
    logic                          addr_phase; // waiting for the address byte
    logic                          csn_q;
    logic                          wr_valid;
    spi_pkg::addr_t                wr_addr;
    spi_pkg::byte_t                wr_data;
    spi_pkg::byte_t                rx_byte;
    logic                          boundary;

    assign rx_byte  = {shift_q, serial_in};
    assign boundary = !csn && (bit_cnt == CNT_W'(spi_pkg::BYTE_BITS - 1));

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            shift_q    <= '0;
            bit_cnt    <= '0;
            addr_phase <= 1'b1;
            cur_addr   <= '0;
            wr_valid   <= 1'b0;
            slot_start <= 1'b0;
        end else if (csn) begin
            // idle between frames, a partial byte is simply dropped here
            shift_q    <= '0;
            bit_cnt    <= '0;
            addr_phase <= 1'b1;
            cur_addr   <= '0;
            wr_valid   <= 1'b0;
            slot_start <= 1'b0;
        end else begin
            shift_q    <= rx_byte[spi_pkg::BYTE_BITS-2:0];
            bit_cnt    <= bit_cnt + 1'b1;   // wraps at the byte boundary
            wr_valid   <= boundary && !addr_phase;
            slot_start <= boundary;
            if (boundary) begin
                if (addr_phase) begin
                    cur_addr   <= rx_byte;
                    addr_phase <= 1'b0;
                end else begin
                    cur_addr <= cur_addr + 1'b1;    // auto-increment, 8-bit wrap
                end
            end
        end
    end

    // payload of the strobe, only meaningful with wr_valid
    always_ff @(posedge sclk) begin
        if (boundary && !addr_phase) begin
            wr_addr <= cur_addr;
            wr_data <= rx_byte;
        end
    end

    assign wr = '{valid: wr_valid, addr: wr_addr, data: wr_data};

    // first edge that sees csn high after a low period
    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            csn_q     <= 1'b1;
            frame_end <= 1'b0;
        end else begin
            csn_q     <= csn;
            frame_end <= csn && !csn_q;
        end
    end

    // a write never overlaps the end-of-frame cycle
    a_wr_not_at_end : assert property (
        @(posedge sclk) disable iff (!rstn) !(wr.valid && frame_end)
    );

endmodule

//--- design/cfg_reg_bank.sv
/*
 * the eight writable configuration registers plus the read-only pll lock byte
 * writes come in as single-cycle strobes, reads are combinational from cur_addr
 */
`timescale 1ns/1ps

module cfg_reg_bank (
    input  logic                  sclk,
    input  logic                  rstn,
    input  spi_pkg::wr_strobe_t   wr,
    input  spi_pkg::addr_t        cur_addr,
    input  spi_pkg::byte_t        pll_locked,
    output regmap_pkg::cfg_regs_t cfg,
    output spi_pkg::byte_t        rd_data
);

    // mapped read value at an address, 0 when unmapped
    function automatic spi_pkg::byte_t read_reg(
        input regmap_pkg::cfg_regs_t regs,
        input spi_pkg::addr_t        addr,
        input spi_pkg::byte_t        lock
    );
        spi_pkg::byte_t val;
        case (addr)
            regmap_pkg::ADDR_TRIG_MASK:   val = regs.trig_mask;
            regmap_pkg::ADDR_INSTRUCTION: val = regs.instruction;
            regmap_pkg::ADDR_MODE:        val = regs.mode;
            regmap_pkg::ADDR_PLL_LOCKED:  val = lock;
            regmap_pkg::ADDR_DISC_POL:    val = regs.disc_pol;
            regmap_pkg::ADDR_VCO_CTRL:    val = regs.vco_ctrl;
            regmap_pkg::ADDR_PLL_DIV:     val = regs.pll_div;
            regmap_pkg::ADDR_SLOW_MODE:   val = regs.slow_mode;
            regmap_pkg::ADDR_TRIG_DELAY:  val = regs.trig_delay;
            default:                      val = '0;
        endcase
        return val;
    endfunction

    function automatic logic is_writable(input spi_pkg::addr_t addr);
        return (addr inside {regmap_pkg::ADDR_TRIG_MASK, regmap_pkg::ADDR_INSTRUCTION,
                             regmap_pkg::ADDR_MODE, regmap_pkg::ADDR_DISC_POL,
                             regmap_pkg::ADDR_VCO_CTRL, regmap_pkg::ADDR_PLL_DIV,
                             regmap_pkg::ADDR_SLOW_MODE, regmap_pkg::ADDR_TRIG_DELAY});
    endfunction

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            cfg <= regmap_pkg::CFG_RESET;
        end else if (wr.valid) begin
            case (wr.addr)
                regmap_pkg::ADDR_TRIG_MASK:   cfg.trig_mask   <= wr.data;
                regmap_pkg::ADDR_INSTRUCTION: cfg.instruction <= wr.data;
                regmap_pkg::ADDR_MODE:        cfg.mode        <= wr.data;
                regmap_pkg::ADDR_DISC_POL:    cfg.disc_pol    <= wr.data;
                regmap_pkg::ADDR_VCO_CTRL:    cfg.vco_ctrl    <= wr.data;
                regmap_pkg::ADDR_PLL_DIV:     cfg.pll_div     <= wr.data;
                regmap_pkg::ADDR_SLOW_MODE:   cfg.slow_mode   <= wr.data;
                regmap_pkg::ADDR_TRIG_DELAY:  cfg.trig_delay  <= wr.data;
                default: ;  // pll lock byte and holes ignore writes
            endcase
        end
    end

    assign rd_data = read_reg(cfg, cur_addr, pll_locked);

    // a strobe from the receiver lands in the addressed field on the next edge
    a_write_lands : assert property (
        @(posedge sclk) disable iff (!rstn)
        (wr.valid && is_writable(wr.addr))
            |=> (read_reg(cfg, $past(wr.addr), pll_locked) == $past(wr.data))
    );

endmodule

//--- design/readback_shifter.sv
/*
 * readback path: loads the addressed register at each byte slot and shifts it out msb first
 * serial_out is held low whenever csn is high
 */
`timescale 1ns/1ps

module readback_shifter (
    input  logic           sclk,
    input  logic           rstn,
    input  logic           csn,
    input  logic           slot_start,
    input  spi_pkg::byte_t rd_data,
    output logic           serial_out
);

    // bits still to go once the msb is on the pin
    logic [spi_pkg::BYTE_BITS-2:0] shift_q;

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            shift_q    <= '0;
            serial_out <= 1'b0;
        end else if (slot_start) begin
            // old register value, sampled before this slot's write lands
            shift_q    <= rd_data[spi_pkg::BYTE_BITS-2:0];
            serial_out <= !csn && rd_data[spi_pkg::BYTE_BITS-1];
        end else begin
            shift_q    <= {shift_q[spi_pkg::BYTE_BITS-3:0], 1'b0};
            serial_out <= !csn && shift_q[spi_pkg::BYTE_BITS-2];   // quiet between frames
        end
    end

endmodule

//--- design/inst_sequencer.sv
/*
 * instruction handling that drives clk_enable while the start code is held
 * and gives one pulse after any frame that wrote the instruction register
 */
`timescale 1ns/1ps

module inst_sequencer (
    input  logic                sclk,
    input  logic                rstn,
    input  spi_pkg::wr_strobe_t wr,
    input  logic                frame_end,
    input  spi_pkg::byte_t      instruction,
    output logic                clk_enable,
    output logic                inst_rst,
    output logic                inst_readout,
    output logic                inst_start
);

    logic pending;  // instruction written during the current frame

    assign clk_enable = (instruction == regmap_pkg::INST_START);

    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            pending <= 1'b0;
        end else if (frame_end) begin
            pending <= 1'b0;
        end else if (wr.valid && wr.addr == regmap_pkg::ADDR_INSTRUCTION) begin
            pending <= 1'b1;
        end
    end

    // registered one-shot decode of the last written code
    always_ff @(posedge sclk or negedge rstn) begin
        if (!rstn) begin
            inst_rst     <= 1'b0;
            inst_readout <= 1'b0;
            inst_start   <= 1'b0;
        end else begin
            inst_rst     <= frame_end && pending && (instruction == regmap_pkg::INST_RESET);
            inst_readout <= frame_end && pending && (instruction == regmap_pkg::INST_READOUT);
            inst_start   <= frame_end && pending && (instruction == regmap_pkg::INST_START);
        end
    end

    a_one_pulse : assert property (
        @(posedge sclk) disable iff (!rstn)
        $onehot0({inst_rst, inst_readout, inst_start})
    );

endmodule

//--- design/spi_periph_top.sv
/*
 * configuration peripheral top: serial receiver, register bank, readback and instruction logic
 * everything runs on sclk, frames are marked by csn low
 */
`timescale 1ns/1ps

module spi_periph_top (
    input  logic                  sclk,
    input  logic                  rstn,
    input  logic                  csn,
    input  logic                  serial_in,
    input  spi_pkg::byte_t        pll_locked,
    output logic                  serial_out,
    output regmap_pkg::cfg_regs_t cfg,
    output logic                  clk_enable,
    output logic                  inst_rst,
    output logic                  inst_readout,
    output logic                  inst_start
);

    spi_pkg::wr_strobe_t wr;
    spi_pkg::addr_t      cur_addr;
    spi_pkg::byte_t      rd_data;
    logic                slot_start;
    logic                frame_end;

    spi_frame_rx i_spi_frame_rx (
        .sclk       (sclk),
        .rstn       (rstn),
        .csn        (csn),
        .serial_in  (serial_in),
        .wr         (wr),
        .cur_addr   (cur_addr),
        .slot_start (slot_start),
        .frame_end  (frame_end)
    );

    cfg_reg_bank i_cfg_reg_bank (
        .sclk       (sclk),
        .rstn       (rstn),
        .wr         (wr),
        .cur_addr   (cur_addr),
        .pll_locked (pll_locked),
        .cfg        (cfg),
        .rd_data    (rd_data)
    );

    readback_shifter i_readback_shifter (
        .sclk       (sclk),
        .rstn       (rstn),
        .csn        (csn),
        .slot_start (slot_start),
        .rd_data    (rd_data),
        .serial_out (serial_out)
    );

    inst_sequencer i_inst_sequencer (
        .sclk         (sclk),
        .rstn         (rstn),
        .wr           (wr),
        .frame_end    (frame_end),
        .instruction  (cfg.instruction),  // current code straight from the bank
        .clk_enable   (clk_enable),
        .inst_rst     (inst_rst),
        .inst_readout (inst_readout),
        .inst_start   (inst_start)
    );

endmodule

//--- tests/spi_scoreboard.sv
/*
 * checker for the configuration peripheral, samples the DUT ports on falling sclk
 * decodes frames from csn and serial_in and compares against a reference register map
 */
`timescale 1ns/1ps

module spi_scoreboard (
    input  logic                  sclk,
    input  logic                  rstn,
    input  logic                  csn,
    input  logic                  serial_in,
    input  spi_pkg::byte_t        pll_locked,
    input  logic                  serial_out,
    input  regmap_pkg::cfg_regs_t cfg,
    input  logic                  clk_enable,
    input  logic                  inst_rst,
    input  logic                  inst_readout,
    input  logic                  inst_start,
    input  logic [7:0]            test_id,
    output int                    err_count,
    output int                    chk_count
);

    localparam int PULSE_WINDOW = 8;   // cycles allowed after csn rises

    regmap_pkg::cfg_regs_t model;
    logic                  in_frame;
    logic                  addr_phase;
    int                    bit_idx;
    spi_pkg::byte_t        shift_v;
    spi_pkg::addr_t        ptr;          // address of the byte in flight
    spi_pkg::byte_t        exp_rd;       // value the host should see for this byte
    logic                  inst_written;
    logic [2:0]            pulse_exp;    // {start, readout, rst}
    logic                  window_open;
    int                    window_left;

    // expected read value, pll lock byte at its own address, holes read 0
    function automatic spi_pkg::byte_t ref_read(input regmap_pkg::cfg_regs_t regs,
                                                input spi_pkg::addr_t addr,
                                                input spi_pkg::byte_t lock);
        case (addr)
            regmap_pkg::ADDR_TRIG_MASK:   return regs.trig_mask;
            regmap_pkg::ADDR_INSTRUCTION: return regs.instruction;
            regmap_pkg::ADDR_MODE:        return regs.mode;
            regmap_pkg::ADDR_PLL_LOCKED:  return lock;
            regmap_pkg::ADDR_DISC_POL:    return regs.disc_pol;
            regmap_pkg::ADDR_VCO_CTRL:    return regs.vco_ctrl;
            regmap_pkg::ADDR_PLL_DIV:     return regs.pll_div;
            regmap_pkg::ADDR_SLOW_MODE:   return regs.slow_mode;
            regmap_pkg::ADDR_TRIG_DELAY:  return regs.trig_delay;
            default:                      return '0;
        endcase
    endfunction

    function automatic regmap_pkg::cfg_regs_t ref_write(input regmap_pkg::cfg_regs_t regs,
                                                        input spi_pkg::addr_t addr,
                                                        input spi_pkg::byte_t data);
        regmap_pkg::cfg_regs_t next;
        next = regs;
        case (addr)
            regmap_pkg::ADDR_TRIG_MASK:   next.trig_mask   = data;
            regmap_pkg::ADDR_INSTRUCTION: next.instruction = data;
            regmap_pkg::ADDR_MODE:        next.mode        = data;
            regmap_pkg::ADDR_DISC_POL:    next.disc_pol    = data;
            regmap_pkg::ADDR_VCO_CTRL:    next.vco_ctrl    = data;
            regmap_pkg::ADDR_PLL_DIV:     next.pll_div     = data;
            regmap_pkg::ADDR_SLOW_MODE:   next.slow_mode   = data;
            regmap_pkg::ADDR_TRIG_DELAY:  next.trig_delay  = data;
            default: ;   // lock byte and holes stay as they are
        endcase
        return next;
    endfunction

    function automatic logic [2:0] expected_pulse(input spi_pkg::byte_t code);
        if (code == regmap_pkg::INST_RESET)   return 3'b001;
        if (code == regmap_pkg::INST_READOUT) return 3'b010;
        if (code == regmap_pkg::INST_START)   return 3'b100;
        return 3'b000;   // unknown code, no pulse
    endfunction

    function automatic string test_label(input logic [7:0] id);
        case (id)
            8'd1:    return "reset_values";
            8'd2:    return "burst_writes";
            8'd3:    return "readback";
            8'd4:    return "instruction_pulses";
            8'd5:    return "clk_enable";
            8'd6:    return "partial_byte";
            8'd7:    return "random_frames";
            default: return "unknown";
        endcase
    endfunction

    task automatic count_check(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        chk_count++;
        if (exp !== act) begin
            err_count++;
            $display("MISMATCH %s: %s expected %h actual %h", test_label(test_id), what, exp, act);
        end
    endtask

    task automatic report_failure(input string msg);
        err_count++;
        $display("ERROR %s: %s", test_label(test_id), msg);
    endtask

    always @(negedge sclk) begin : monitor
        logic [2:0] seen;
        seen = {inst_start, inst_readout, inst_rst};
        if (!rstn) begin
            model        = regmap_pkg::CFG_RESET;
            in_frame     = 1'b0;
            addr_phase   = 1'b1;
            bit_idx      = 0;
            shift_v      = '0;
            ptr          = '0;
            exp_rd       = '0;
            inst_written = 1'b0;
            pulse_exp    = '0;
            window_open  = 1'b0;
            window_left  = 0;
        end else begin
            if (window_open) begin
                if (seen != 3'b000) begin
                    count_check("instruction pulse", 64'(pulse_exp), 64'(seen));
                    window_open = 1'b0;
                end else if (window_left <= 1) begin
                    report_failure("no instruction pulse within 8 cycles after csn rose");
                    window_open = 1'b0;
                end else begin
                    window_left--;
                end
            end else if (seen != 3'b000) begin
                report_failure($sformatf("instruction pulse %b without a pending write", seen));
            end

            if (!csn) begin
                if (!in_frame) begin
                    in_frame     = 1'b1;
                    addr_phase   = 1'b1;
                    bit_idx      = 0;
                    inst_written = 1'b0;
                end
                shift_v = {shift_v[6:0], serial_in};
                if (!addr_phase) begin
                    // old value, taken as the byte starts
                    if (bit_idx == 0) exp_rd = ref_read(model, ptr, pll_locked);
                    count_check($sformatf("readback addr %0d bit %0d", ptr, 7 - bit_idx),
                                64'(exp_rd[7 - bit_idx]), 64'(serial_out));
                end
                if (bit_idx == 7) begin
                    if (addr_phase) begin
                        ptr        = shift_v;
                        addr_phase = 1'b0;
                    end else begin
                        model = ref_write(model, ptr, shift_v);
                        if (ptr == regmap_pkg::ADDR_INSTRUCTION) inst_written = 1'b1;
                        ptr = ptr + 8'd1;   // wraps at 8 bits
                    end
                    bit_idx = 0;
                end else begin
                    bit_idx++;
                end
            end else begin
                if (in_frame) begin
                    in_frame  = 1'b0;   // partial byte dropped here
                    pulse_exp = expected_pulse(model.instruction);
                    if (inst_written && pulse_exp != 3'b000) begin
                        window_open = 1'b1;
                        window_left = PULSE_WINDOW;
                    end
                end
                count_check("cfg", 64'(cfg), 64'(model));
                count_check("clk_enable", 64'(model.instruction == regmap_pkg::INST_START),
                            64'(clk_enable));
                count_check("serial_out while idle", 64'd0, 64'(serial_out));
            end
        end
    end

endmodule

//--- tests/tb_spi_periph.sv
/*
 * testbench for the configuration peripheral: clock, reset and serial frames on falling sclk
 * the scoreboard instance compares, this module prints the verdict
 */
`timescale 1ns/1ps

module tb_spi_periph;

    localparam int HALF_PERIOD  = 2;       // 4 ns clock
    localparam int RESET_CYCLES = 4;
    localparam int GAP_CYCLES   = 12;      // idle between frames, covers the pulse window
    localparam int RUN_LIMIT    = 20000;
    localparam int MAX_BYTES    = 8;

    logic                  sclk;
    logic                  rstn;
    logic                  csn;
    logic                  serial_in;
    spi_pkg::byte_t        pll_locked;
    logic                  serial_out;
    regmap_pkg::cfg_regs_t cfg;
    logic                  clk_enable;
    logic                  inst_rst;
    logic                  inst_readout;
    logic                  inst_start;
    logic [7:0]            test_id;
    int                    err_count;
    int                    chk_count;
    logic [31:0]           lcg_state;
    spi_pkg::byte_t        frame_data [MAX_BYTES];

    spi_periph_top i_spi_periph_top (
        .sclk (sclk), .rstn (rstn), .csn (csn), .serial_in (serial_in),
        .pll_locked (pll_locked), .serial_out (serial_out), .cfg (cfg),
        .clk_enable (clk_enable), .inst_rst (inst_rst), .inst_readout (inst_readout),
        .inst_start (inst_start)
    );

    spi_scoreboard i_spi_scoreboard (
        .sclk (sclk), .rstn (rstn), .csn (csn), .serial_in (serial_in),
        .pll_locked (pll_locked), .serial_out (serial_out), .cfg (cfg),
        .clk_enable (clk_enable), .inst_rst (inst_rst), .inst_readout (inst_readout),
        .inst_start (inst_start), .test_id (test_id), .err_count (err_count),
        .chk_count (chk_count)
    );

    initial begin
        sclk = 1'b0;
        forever #HALF_PERIOD sclk = ~sclk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        lcg_state = lcg_step(lcg_state);
        r = lcg_state;
    endtask

    task automatic fill_random(input int n);
        logic [31:0] r;
        for (int j = 0; j < n; j++) begin
            draw_random(r);
            frame_data[j] = r[23:16];   // upper bits, low LCG bits cycle fast
        end
    endtask

    task automatic idle_cycles(input int n);
        for (int i = 0; i < n; i++) @(negedge sclk);
    endtask

    // msb first, one bit per falling edge
    task automatic shift_bits(input spi_pkg::byte_t b, input int nbits);
        for (int i = 0; i < nbits; i++) begin
            serial_in <= b[7 - i];
            @(negedge sclk);
        end
    endtask

    task automatic send_frame(input spi_pkg::addr_t addr, input int addr_bits, input int nbytes,
                              input int tail_bits, input spi_pkg::byte_t tail);
        @(negedge sclk);
        csn <= 1'b0;
        shift_bits(addr, addr_bits);
        for (int j = 0; j < nbytes; j++) shift_bits(frame_data[j], 8);
        if (tail_bits > 0) shift_bits(tail, tail_bits);
        csn       <= 1'b1;
        serial_in <= 1'b0;
        idle_cycles(GAP_CYCLES);
    endtask

    task automatic write_one(input spi_pkg::addr_t addr, input spi_pkg::byte_t data);
        frame_data[0] = data;
        send_frame(addr, 8, 1, 0, '0);
    endtask

    function automatic spi_pkg::addr_t mapped_addr(input int idx);
        case (idx)
            0:       return regmap_pkg::ADDR_TRIG_MASK;
            1:       return regmap_pkg::ADDR_INSTRUCTION;
            2:       return regmap_pkg::ADDR_MODE;
            3:       return regmap_pkg::ADDR_PLL_LOCKED;
            4:       return regmap_pkg::ADDR_DISC_POL;
            5:       return regmap_pkg::ADDR_VCO_CTRL;
            6:       return regmap_pkg::ADDR_PLL_DIV;
            7:       return regmap_pkg::ADDR_SLOW_MODE;
            default: return regmap_pkg::ADDR_TRIG_DELAY;
        endcase
    endfunction

    initial begin
        logic [31:0]    r;
        spi_pkg::addr_t start;
        int             nbytes;
        int             tail_bits;
        csn        = 1'b1;
        serial_in  = 1'b0;
        pll_locked = '0;
        rstn       = 1'b0;
        test_id    = 8'd1;
        lcg_state  = 32'h44a9_f890;
        idle_cycles(RESET_CYCLES);
        rstn <= 1'b1;
        idle_cycles(GAP_CYCLES);     // reset values checked while idle

        test_id <= 8'd2;
        draw_random(r);
        pll_locked <= r[23:16];
        fill_random(5);
        send_frame(regmap_pkg::ADDR_DISC_POL, 8, 5, 0, '0);
        draw_random(r);
        write_one(regmap_pkg::ADDR_PLL_LOCKED, r[23:16]);   // read-only, no effect

        test_id <= 8'd3;
        draw_random(r);
        pll_locked <= r[23:16];
        fill_random(3);
        send_frame(regmap_pkg::ADDR_TRIG_MASK, 8, 3, 0, '0);
        fill_random(6);
        send_frame(regmap_pkg::ADDR_PLL_LOCKED, 8, 6, 0, '0);

        test_id <= 8'd4;
        write_one(regmap_pkg::ADDR_INSTRUCTION, regmap_pkg::INST_RESET);
        write_one(regmap_pkg::ADDR_INSTRUCTION, regmap_pkg::INST_READOUT);
        write_one(regmap_pkg::ADDR_INSTRUCTION, regmap_pkg::INST_START);
        draw_random(r);
        write_one(regmap_pkg::ADDR_MODE, r[23:16]);          // no pulse expected
        write_one(regmap_pkg::ADDR_INSTRUCTION, 8'h00);
        fill_random(3);
        frame_data[1] = regmap_pkg::INST_READOUT;            // instruction inside a burst
        send_frame(regmap_pkg::ADDR_TRIG_MASK, 8, 3, 0, '0);

        test_id <= 8'd5;
        write_one(regmap_pkg::ADDR_INSTRUCTION, regmap_pkg::INST_START);
        draw_random(r);
        write_one(regmap_pkg::ADDR_SLOW_MODE, r[23:16]);
        write_one(regmap_pkg::ADDR_INSTRUCTION, 8'h00);

        test_id <= 8'd6;
        fill_random(1);
        draw_random(r);
        send_frame(regmap_pkg::ADDR_SLOW_MODE, 8, 1, 5, r[23:16]);
        send_frame(regmap_pkg::ADDR_TRIG_MASK, 5, 0, 0, '0);   // address cut short

        test_id <= 8'd7;
        for (int f = 0; f < 20; f++) begin
            draw_random(r);
            start     = r[31] ? r[23:16] : mapped_addr(int'(r[30:27]) % 9);
            nbytes    = int'(r[26:24]) % 6 + 1;
            tail_bits = r[15] ? int'(r[14:12]) : 0;
            pll_locked <= r[11:4];
            fill_random(nbytes);
            draw_random(r);
            send_frame(start, 8, nbytes, tail_bits, r[23:16]);
        end
        idle_cycles(GAP_CYCLES);

        $display("checks: %0d, errors: %0d", chk_count, err_count);
        if (err_count == 0 && chk_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            if (chk_count == 0) $display("the scoreboard made no checks");
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog, the stimulus must finish well inside this
    initial begin
        for (int i = 0; i < RUN_LIMIT; i++) @(posedge sclk);
        $display("simulation did not finish within %0d cycles", RUN_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- vlog.f
design/spi_pkg.sv
design/regmap_pkg.sv
design/spi_frame_rx.sv
design/cfg_reg_bank.sv
design/readback_shifter.sv
design/inst_sequencer.sv
design/spi_periph_top.sv
tests/spi_scoreboard.sv
tests/tb_spi_periph.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the peripheral testbench with Verilator, fail on the fail message
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 -Wno-fatal \
    --top-module tb_spi_periph -f vlog.f
./obj_dir/Vtb_spi_periph | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "simulation reported failures"
    exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation ended without a verdict"
    exit 1
fi
